/* design/memsys_pkg.sv */
`default_nettype none

package memsys_pkg;

  localparam int ADDR_W      = 32;
  localparam int WORD_W      = 32;
  localparam int BLOCK_W     = 128;
  localparam int BYTE_OFF_W  = 2;  // byte within word
  localparam int WORD_OFF_W  = 2;  // word within block, addr[3:2]
  localparam int BLOCK_OFF_W = BYTE_OFF_W + WORD_OFF_W;

  localparam int DRAM_LATENCY_DEFAULT = 15;

  typedef logic [WORD_W-1:0]             word_t;
  typedef logic [BLOCK_W-1:0]            block_t;
  typedef logic [BLOCK_W/8-1:0]          bmask_t;  // set bit keeps the byte
  typedef logic [WORD_W/8-1:0]           ben_t;
  typedef logic [ADDR_W-BLOCK_OFF_W-1:0] baddr_t;  // dram block address

  typedef enum logic [2:0] {
    IDLE,
    CACHE_READ,
    WRITE_THROUGH,
    WRITE_ISSUE,
    READ_ISSUE,
    READ_WAIT,
    SAVE_RESULT,
    COMPLETE_READ
  } task_e;

  typedef enum logic [1:0] {
    DRAM_NOP,
    DRAM_READ,
    DRAM_WRITE
  } dram_cmd_e;

endpackage

`default_nettype wire

/* design/mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if #(
  parameter int INDEX_WIDTH = 6
);
  import memsys_pkg::*;

  localparam int TAG_W = ADDR_W - INDEX_WIDTH - BLOCK_OFF_W;

  logic                  rd;        // captured read, one cycle after accept
  ben_t                  wen;       // captured byte enables, same timing
  word_t                 addr;
  word_t                 wdata;
  logic [TAG_W-1:0]      tag;
  logic [INDEX_WIDTH-1:0] idx;
  logic [WORD_OFF_W-1:0] woff;
  logic [TAG_W-1:0]      live_tag;  // incoming address, not yet captured
  logic [INDEX_WIDTH-1:0] live_idx;

  modport decode_mp (output rd, wen, addr, wdata, tag, idx, woff, live_tag, live_idx);
  modport cache_mp  (input  rd, wen, addr, wdata, tag, idx, woff, live_tag, live_idx);
  modport ctrl_mp   (input  rd, wen, addr, wdata, tag, idx, woff, live_tag, live_idx);

endinterface

`default_nettype wire

/* design/req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module req_decode #(
  parameter int INDEX_WIDTH = 6
) (
  input  wire                i_clk,
  input  wire                i_rst,
  input  wire                i_accept,
  input  wire                i_ren,
  input  memsys_pkg::ben_t   i_wen,
  input  memsys_pkg::word_t  i_addr,
  input  memsys_pkg::word_t  i_wdata,
  mem_req_if.decode_mp       req
);
  import memsys_pkg::*;

  localparam int TAG_W = ADDR_W - INDEX_WIDTH - BLOCK_OFF_W;

  // strobes only live for the cycle after accept
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      req.rd  <= 1'b0;
      req.wen <= '0;
    end else begin
      req.rd  <= i_accept && i_ren;
      req.wen <= i_accept ? i_wen : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_accept) begin
      req.addr  <= i_addr;
      req.wdata <= i_wdata;
    end
  end

  assign req.tag  = req.addr[ADDR_W-1 -: TAG_W];
  assign req.idx  = req.addr[BLOCK_OFF_W +: INDEX_WIDTH];
  assign req.woff = req.addr[BYTE_OFF_W +: WORD_OFF_W];

  assign req.live_tag = i_addr[ADDR_W-1 -: TAG_W];
  assign req.live_idx = i_addr[BLOCK_OFF_W +: INDEX_WIDTH];

  a_no_rd_wr : assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_ren && (i_wen != '0)))
    else $error("read and write requested together");

endmodule

`default_nettype wire

/* design/cache_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
  parameter int INDEX_WIDTH = 6
) (
  input  wire                 i_clk,
  input  wire                 i_rst,
  mem_req_if.cache_mp         req,
  input  wire                 i_install,
  input  memsys_pkg::block_t  i_install_block,
  output logic                o_hit,
  output memsys_pkg::block_t  o_block
);
  import memsys_pkg::*;

  localparam int TAG_W = ADDR_W - INDEX_WIDTH - BLOCK_OFF_W;
  localparam int LINES = 2 ** INDEX_WIDTH;

  logic [LINES-1:0] valid;
  logic [TAG_W-1:0] tags [LINES];
  block_t           data [LINES];

  logic   r_hit;
  block_t r_block;
  logic   wr_hit;

  // r_hit still refers to the address of the write
  assign wr_hit = (req.wen != '0) && r_hit;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      valid <= '0;
      r_hit <= 1'b0;
    end else begin
      if (i_install) begin
        valid[req.idx] <= 1'b1;
      end
      // lookup on the incoming address every cycle
      r_hit <= valid[req.live_idx] && (tags[req.live_idx] == req.live_tag);
    end
  end

  always_ff @(posedge i_clk) begin
    r_block <= data[req.live_idx];
    if (i_install) begin
      tags[req.idx] <= req.tag;
      data[req.idx] <= i_install_block;
    end else if (wr_hit) begin
      for (int j = 0; j < $bits(ben_t); j++) begin
        if (req.wen[j]) begin
          data[req.idx][req.woff*WORD_W + j*8 +: 8] <= req.wdata[j*8 +: 8];
        end
      end
    end
  end

  assign o_hit   = r_hit;
  assign o_block = r_block;

  // install comes from the controller, write hit from the captured request
  a_no_install_on_write : assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_install && wr_hit))
    else $error("install collides with write hit");

endmodule

`default_nettype wire

/* design/miss_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_controller (
  input  wire                 i_clk,
  input  wire                 i_rst,
  input  wire                 i_ren,
  input  memsys_pkg::ben_t    i_wen,
  mem_req_if.ctrl_mp          req,
  input  wire                 i_hit,
  input  memsys_pkg::block_t  i_block,
  input  wire                 i_dram_busy,
  input  memsys_pkg::block_t  i_dram_rdata,
  input  wire                 i_dram_rvalid,
  output logic                o_accept,
  output logic                o_install,
  output memsys_pkg::block_t  o_install_block,
  output logic                o_dram_ren,
  output logic                o_dram_wen,
  output memsys_pkg::baddr_t  o_dram_addr,
  output memsys_pkg::block_t  o_dram_wdata,
  output memsys_pkg::bmask_t  o_dram_mask,
  output memsys_pkg::word_t   o_rdata,
  output logic                o_stall
);
  import memsys_pkg::*;

  task_e     task_q;    // task of the previous cycle
  task_e     cur_task;
  task_e     new_task;
  dram_cmd_e dram_cmd;
  block_t    saved_block;
  block_t    raw_block;
  logic      req_present;

  assign req_present = i_ren || (i_wen != '0);

  always_comb begin
    new_task = IDLE;
    if (i_ren) begin
      new_task = CACHE_READ;
    end else if (i_wen != '0) begin
      new_task = WRITE_THROUGH;
    end
  end

  // current task follows from the previous one
  always_comb begin
    cur_task = new_task;
    case (task_q)
      CACHE_READ:    if (req.rd && !i_hit) cur_task = READ_ISSUE;
      WRITE_THROUGH: cur_task = WRITE_ISSUE;
      READ_ISSUE:    cur_task = READ_WAIT;
      READ_WAIT:     cur_task = i_dram_rvalid ? SAVE_RESULT : READ_WAIT;
      SAVE_RESULT:   cur_task = COMPLETE_READ;
      default:       cur_task = new_task;  // idle, write issue, complete read
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      task_q <= IDLE;
    end else begin
      task_q <= cur_task;
    end
  end

  always_ff @(posedge i_clk) begin
    if (cur_task == SAVE_RESULT) begin
      saved_block <= i_dram_rdata;
    end
  end

  assign o_accept = (cur_task == CACHE_READ) || (cur_task == WRITE_THROUGH);

  // a new request in write issue waits one cycle for the cache update
  assign o_stall = (cur_task == READ_ISSUE) || (cur_task == READ_WAIT) ||
                   (cur_task == SAVE_RESULT) ||
                   ((cur_task == WRITE_ISSUE) && req_present);

  assign o_install       = (cur_task == COMPLETE_READ);
  assign o_install_block = saved_block;

  always_comb begin
    case (cur_task)
      READ_ISSUE:  dram_cmd = DRAM_READ;
      WRITE_ISSUE: dram_cmd = DRAM_WRITE;
      default:     dram_cmd = DRAM_NOP;
    endcase
  end

  assign o_dram_ren  = (dram_cmd == DRAM_READ);
  assign o_dram_wen  = (dram_cmd == DRAM_WRITE);
  assign o_dram_addr = req.addr[ADDR_W-1:BLOCK_OFF_W];

  // word into its lane, mask keeps every other byte
  always_comb begin
    o_dram_wdata = '0;
    o_dram_wdata[req.woff*WORD_W +: WORD_W] = req.wdata;
    o_dram_mask = '1;
    o_dram_mask[req.woff*$bits(ben_t) +: $bits(ben_t)] = ~req.wen;
  end

  assign raw_block = (cur_task == COMPLETE_READ) ? saved_block : i_block;
  assign o_rdata   = raw_block[req.woff*WORD_W +: WORD_W];

  a_read_not_busy : assert property (@(posedge i_clk) disable iff (i_rst)
    o_dram_ren |-> !i_dram_busy)
    else $error("dram read issued while busy");

endmodule

`default_nettype wire

/* design/dram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module dram_model #(
  parameter int DRAM_DEPTH_LOG2 = 10,
  parameter int DRAM_LATENCY    = memsys_pkg::DRAM_LATENCY_DEFAULT
) (
  input  wire                 i_clk,
  input  wire                 i_rst,
  input  wire                 i_ren,
  input  wire                 i_wen,
  input  memsys_pkg::baddr_t  i_addr,
  input  memsys_pkg::block_t  i_wdata,
  input  memsys_pkg::bmask_t  i_mask,
  output memsys_pkg::block_t  o_rdata,
  output logic                o_rvalid,
  output logic                o_busy
);
  import memsys_pkg::*;

  localparam int DEPTH = 2 ** DRAM_DEPTH_LOG2;
  localparam int CNT_W = $clog2(DRAM_LATENCY + 1);

  block_t mem [DEPTH];

  logic [DRAM_DEPTH_LOG2-1:0] waddr;
  logic [DRAM_DEPTH_LOG2-1:0] r_raddr;
  logic [CNT_W-1:0]           r_count;
  logic                       r_pending;
  logic                       r_rvalid;
  block_t                     r_rdata;

  assign waddr = i_addr[DRAM_DEPTH_LOG2-1:0];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // masked bytes are kept
  always @(posedge i_clk) begin
    if (i_wen) begin
      for (int j = 0; j < $bits(bmask_t); j++) begin
        if (!i_mask[j]) begin
          mem[waddr][j*8 +: 8] <= i_wdata[j*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_pending <= 1'b0;
      r_rvalid  <= 1'b0;
      r_count   <= '0;
    end else begin
      r_rvalid <= 1'b0;
      if (i_ren) begin
        r_pending <= 1'b1;
        r_count   <= CNT_W'(DRAM_LATENCY - 1);
      end else if (r_pending) begin
        if (r_count == CNT_W'(1)) begin
          r_pending <= 1'b0;
          r_rvalid  <= 1'b1;  // latency cycles after the strobe
        end
        r_count <= r_count - 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ren) begin
      r_raddr <= waddr;
    end
    if (r_pending && (r_count == CNT_W'(1))) begin
      r_rdata <= mem[r_raddr];
    end
  end

  assign o_rdata  = r_rdata;
  assign o_rvalid = r_rvalid;
  assign o_busy   = r_pending;

  a_single_read : assert property (@(posedge i_clk) disable iff (i_rst)
    i_ren |-> !o_busy)
    else $error("second dram read while one is outstanding");

endmodule

`default_nettype wire

/* design/cached_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module cached_memory #(
  parameter int INDEX_WIDTH     = 6,
  parameter int DRAM_DEPTH_LOG2 = 10,
  parameter int DRAM_LATENCY    = memsys_pkg::DRAM_LATENCY_DEFAULT
) (
  input  wire                i_clk,
  input  wire                i_rst,
  input  wire                i_ren,
  input  memsys_pkg::ben_t   i_wen,
  input  memsys_pkg::word_t  i_addr,
  input  memsys_pkg::word_t  i_wdata,
  output memsys_pkg::word_t  o_rdata,
  output logic               o_stall
);
  import memsys_pkg::*;

  logic   accept;
  logic   hit;
  block_t cache_block;
  logic   install;
  block_t install_block;
  logic   dram_ren;
  logic   dram_wen;
  baddr_t dram_addr;
  block_t dram_wdata;
  bmask_t dram_mask;
  block_t dram_rdata;
  logic   dram_rvalid;
  logic   dram_busy;

  mem_req_if #(.INDEX_WIDTH(INDEX_WIDTH)) req_if ();

  req_decode #(.INDEX_WIDTH(INDEX_WIDTH)) req_decode_inst (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_accept (accept),
    .i_ren    (i_ren),
    .i_wen    (i_wen),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .req      (req_if.decode_mp)
  );

  cache_array #(.INDEX_WIDTH(INDEX_WIDTH)) cache_array_inst (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .req             (req_if.cache_mp),
    .i_install       (install),
    .i_install_block (install_block),
    .o_hit           (hit),
    .o_block         (cache_block)
  );

  miss_controller miss_controller_inst (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_ren           (i_ren),
    .i_wen           (i_wen),
    .req             (req_if.ctrl_mp),
    .i_hit           (hit),
    .i_block         (cache_block),
    .i_dram_busy     (dram_busy),
    .i_dram_rdata    (dram_rdata),
    .i_dram_rvalid   (dram_rvalid),
    .o_accept        (accept),
    .o_install       (install),
    .o_install_block (install_block),
    .o_dram_ren      (dram_ren),
    .o_dram_wen      (dram_wen),
    .o_dram_addr     (dram_addr),
    .o_dram_wdata    (dram_wdata),
    .o_dram_mask     (dram_mask),
    .o_rdata         (o_rdata),
    .o_stall         (o_stall)
  );

  dram_model #(
    .DRAM_DEPTH_LOG2 (DRAM_DEPTH_LOG2),
    .DRAM_LATENCY    (DRAM_LATENCY)
  ) dram_model_inst (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_ren    (dram_ren),
    .i_wen    (dram_wen),
    .i_addr   (dram_addr),
    .i_wdata  (dram_wdata),
    .i_mask   (dram_mask),
    .o_rdata  (dram_rdata),
    .o_rvalid (dram_rvalid),
    .o_busy   (dram_busy)
  );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // sync reset, dropped right after the last reset edge
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* verif/tb_cached_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cached_memory;
  import memsys_pkg::*;

  localparam int         MAX_VEC  = 64;
  localparam int         TIMEOUT  = 100;
  localparam logic [3:0] OP_END   = 4'd0;
  localparam logic [3:0] OP_WRITE = 4'd1;
  localparam logic [3:0] OP_HIT   = 4'd3;  // 2 is a read that must miss

  logic  clk;
  logic  rst;
  logic  ren;
  ben_t  wen;
  word_t addr;
  word_t wdata;
  word_t rdata;
  logic  stall;

  logic [103:0] vecs [MAX_VEC];  // op, addr, wdata, ben, expected
  word_t        shadow [word_t];  // keyed by word address
  int           mismatches;
  int           failures;
  logic         hung;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) clock_gen_inst (.o_clk(clk), .o_rst(rst));

  cached_memory #(
    .INDEX_WIDTH     (6),
    .DRAM_DEPTH_LOG2 (10),
    .DRAM_LATENCY    (15)
  ) cached_memory_inst (
    .i_clk   (clk),
    .i_rst   (rst),
    .i_ren   (ren),
    .i_wen   (wen),
    .i_addr  (addr),
    .i_wdata (wdata),
    .o_rdata (rdata),
    .o_stall (stall)
  );

  function automatic word_t shadow_word(input word_t a);
    return shadow.exists(a >> 2) ? shadow[a >> 2] : '0;
  endfunction

  function automatic void merge_write(input word_t a, input word_t d, input ben_t be);
    word_t w;
    w = shadow_word(a);
    for (int b = 0; b < $bits(ben_t); b++) begin
      if (be[b]) w[b*8 +: 8] = d[b*8 +: 8];
    end
    shadow[a >> 2] = w;
  endfunction

  task automatic finish_run();
    $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // counts rising edges until one sees o_stall low
  task automatic wait_no_stall(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (stall && cycles < TIMEOUT);
    assert (!stall) else begin
      $display("%0t: o_stall still high after %0d cycles, giving up", $time, TIMEOUT);
      failures++;
      hung = 1'b1;
    end
  endtask

  task automatic compare_word(input string what, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("MISMATCH %0t o_rdata (%s) got %h expected %h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  initial begin
    int         n;
    int         cycles;
    logic [3:0] op;
    word_t      vaddr;
    word_t      vdata;
    ben_t       vben;
    word_t      vexp;
    logic       prev_write;
    ren        = 1'b0;
    wen        = '0;
    addr       = '0;
    wdata      = '0;
    mismatches = 0;
    failures   = 0;
    hung       = 1'b0;
    prev_write = 1'b0;
    $readmemh("verif/mem_input.txt", vecs);

    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while ((rst || stall) && cycles < TIMEOUT);
    assert (!rst && !stall) else begin
      $display("%0t: DUT not idle within %0d cycles of reset", $time, TIMEOUT);
      failures++;
      hung = 1'b1;
    end

    for (n = 0; n < MAX_VEC && !hung; n++) begin
      {op, vaddr, vdata, vben, vexp} = vecs[n];
      if (op == OP_END) break;
      @(negedge clk);
      addr  = vaddr;
      wdata = vdata;
      ren   = (op != OP_WRITE);
      wen   = (op == OP_WRITE) ? vben : '0;
      wait_no_stall(cycles);  // acceptance edge
      if (hung) break;
      // a request right behind a write sits out the write issue cycle
      assert (cycles == (prev_write ? 2 : 1)) else begin
        $display("%0t: request %0d accepted after %0d cycles, expected %0d", $time, n,
                 cycles, prev_write ? 2 : 1);
        failures++;
      end
      prev_write = (op == OP_WRITE);
      if (op == OP_WRITE) begin
        merge_write(vaddr, vdata, vben);
      end else begin
        @(negedge clk);
        ren = 1'b0;
        wait_no_stall(cycles);
        if (hung) break;
        compare_word("file", rdata, vexp);
        compare_word("shadow", rdata, shadow_word(vaddr));
        assert ((op == OP_HIT) ? (cycles == 1) : (cycles > 1)) else begin
          $display("%0t: read of %h took %0d cycles, wrong for a %s", $time, vaddr, cycles,
                   (op == OP_HIT) ? "hit" : "miss");
          failures++;
        end
      end
    end

    if (!hung) begin
      @(negedge clk);
      ren = 1'b0;
      wen = '0;
      wait_no_stall(cycles);
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* verif/mem_input.txt */
// columns: op _ address _ write data _ byte enables _ expected read data, all hex
// op 1 write, 2 read that misses, 3 read that hits, 0 ends the list
2_00000100_00000000_0_00000000
1_00000040_12345678_f_00000000
2_00000040_00000000_0_12345678
3_00000040_00000000_0_12345678
1_00000040_aabbccdd_1_00000000
3_00000040_00000000_0_123456dd
1_00000040_99887766_c_00000000
3_00000040_00000000_0_998856dd
// same index, other tag
1_00000440_cafef00d_f_00000000
2_00000440_00000000_0_cafef00d
2_00000040_00000000_0_998856dd
1_00000444_01020304_f_00000000
2_00000440_00000000_0_cafef00d
3_00000444_00000000_0_01020304
// write then read straight away in the same block
1_00000448_5a5a5a5a_f_00000000
3_00000444_00000000_0_01020304
3_00000448_00000000_0_5a5a5a5a
1_0000044c_0badf00d_3_00000000
3_0000044c_00000000_0_0000f00d
3_00000104_00000000_0_00000000
0_00000000_00000000_0_00000000

/* project.f */
design/memsys_pkg.sv
design/mem_req_if.sv
design/req_decode.sv
design/cache_array.sv
design/miss_controller.sv
design/dram_model.sv
design/cached_memory.sv
verif/tb_clock_gen.sv
verif/tb_cached_memory.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cached_memory \
  -f project.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_cached_memory > sim.log 2>&1
cat sim.log
grep -qx "TB PASSED" sim.log && exit 0 || exit 1
